/* hw/shb_cfg.svh */
// ####################
// shared bus config macros
// register window base, boot bank,
// physical region codes
// ####################
`ifndef SHB_CFG_SVH
`define SHB_CFG_SVH

// cpu address of the 256 byte register window
`define SHB_REG_BASE   16'hF000

// bank 7 after reset, both cpus boot from here
`define SHB_BOOT_BANK  9'h07F

// region codes live in physical bits 21:20
// rom takes both 00 and 01
`define SHB_RGN_ROM    2'b00
`define SHB_RGN_RAM    2'b10
`define SHB_RGN_KEY    2'b11

// bank writes take bank bit 8 from this cpu address bit
`define SHB_BANK_HI_BIT 4

`endif

/* hw/shb_bus_pkg.sv */
// ####################
// bus package
// cpu request, physical request,
// master id
// ####################
`default_nettype none

package shb_bus_pkg;

    // what a cpu port presents while req is high
    typedef struct packed {
        logic [15:0] addr;     // 6809 style 16 bit address
        logic [ 7:0] wdata;    // ignored on reads
        logic        rnw;      // 1 = read
    } cpu_req_t;               // 25 bits

    // request after banking, as seen by memories
    typedef struct packed {
        logic [21:0] addr;     // bank + page offset
        logic [ 7:0] wdata;
        logic        rnw;
    } phys_req_t;              // 31 bits

    // which cpu owns the bus
    // value doubles as index into per cpu arrays
    typedef enum logic {
        MAIN = 1'b0,
        SUB  = 1'b1
    } master_e;

endpackage

`default_nettype wire

/* hw/shb_map_pkg.sv */
// ####################
// mapping package
// physical address union,
// region codes, register offsets
// ####################
`default_nettype none

`include "shb_cfg.svh"

package shb_map_pkg;

    // one physical word, two decodes
    typedef union packed {
        struct packed {
            logic [ 8:0] bank;   // from bank register
            logic [12:0] off;    // 8 KB page offset
        } page;
        struct packed {
            logic [ 1:0] rgn;    // chip select decode
            logic [19:0] off;    // offset inside region
        } region;
    } phys_addr_u;

    typedef enum logic [1:0] {
        RGN_ROM  = `SHB_RGN_ROM,
        RGN_ROM1 = `SHB_RGN_ROM | 2'b01,  // upper rom half
        RGN_RAM  = `SHB_RGN_RAM,
        RGN_KEY  = `SHB_RGN_KEY
    } region_e;

    // low byte of a register window address
    typedef enum logic [7:0] {
        BANK0   = 8'd0,
        BANK1   = 8'd1,
        BANK2   = 8'd2,
        BANK3   = 8'd3,
        BANK4   = 8'd4,
        BANK5   = 8'd5,
        BANK6   = 8'd6,
        BANK7   = 8'd7,
        SUB_RST = 8'd8,   // main only, bit 0 -> srst_n
        IRQ_ACK = 8'd9    // read returns pending, clears it
    } reg_off_e;

endpackage

`default_nettype wire

/* hw/shb_arbiter.sv */
// ####################
// two master bus arbiter
// alternating grant, four phase req/ack,
// memory wait via ok levels
// ####################
`timescale 1ns/1ps
`default_nettype none

module shb_arbiter(
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    main_req,
    input  shb_bus_pkg::cpu_req_t  main_cmd,
    output logic                   main_ack,
    output logic [7:0]             main_rdata,

    input  wire                    sub_req,
    input  shb_bus_pkg::cpu_req_t  sub_cmd,
    output logic                   sub_ack,
    output logic [7:0]             sub_rdata,

    // towards mapper
    output logic                   grant_valid,
    output shb_bus_pkg::master_e   grant_who,
    output shb_bus_pkg::cpu_req_t  grant_cmd,
    output logic                   grant_done,   // access finishes this cycle
    input  wire                    is_reg,
    input  wire  [7:0]             reg_rdata,

    // memory side
    input  wire                    rom_cs,
    input  wire                    ram_cs,
    input  wire                    key_cs,
    input  wire                    rom_ok,
    input  wire                    ram_ok,
    input  wire  [7:0]             rom_data,
    input  wire  [7:0]             ram_dout,
    input  wire  [7:0]             key_dout,
    output logic                   bus_busy
);
    import shb_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,   // grant out, waiting for reg path or ok
        ST_DONE      // ack high until req drops
    } state_e;

    state_e      state;
    master_e     last;       // last served master
    master_e     pick;
    logic        hit;        // ok seen, ack goes up next edge
    logic        mem_ok;
    logic        cur_req;
    logic [7:0]  mem_data;
    logic [7:0]  mem_q;

    // key chip has no ok, always ready
    assign bus_busy = (rom_cs & ~rom_ok) | (ram_cs & ~ram_ok);
    assign mem_ok   = (rom_cs | ram_cs | key_cs) & ~bus_busy;
    assign mem_data = rom_cs ? rom_data :
                      ram_cs ? ram_dout : key_dout;

    assign grant_done = (state == ST_ACCESS) & (is_reg | hit);
    assign cur_req    = (grant_who == MAIN) ? main_req : sub_req;

    // on a tie the one not served last wins
    always_comb begin
        if (main_req && sub_req) pick = (last == MAIN) ? SUB : MAIN;
        else if (sub_req)        pick = SUB;
        else                     pick = MAIN;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            last        <= SUB;    // main wins first tie
            grant_valid <= 1'b0;
            grant_who   <= MAIN;
            hit         <= 1'b0;
            main_ack    <= 1'b0;
            sub_ack     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (main_req || sub_req) begin
                    grant_valid <= 1'b1;
                    grant_who   <= pick;
                    last        <= pick;
                    hit         <= 1'b0;
                    state       <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    if (grant_done) begin
                        if (grant_who == MAIN) main_ack <= 1'b1;
                        else                   sub_ack  <= 1'b1;
                        state <= ST_DONE;
                    end else if (mem_ok) begin
                        hit <= 1'b1;   // data latched below
                    end
                end
                ST_DONE: if (!cur_req) begin
                    // release, next cycle is idle
                    main_ack    <= 1'b0;
                    sub_ack     <= 1'b0;
                    grant_valid <= 1'b0;
                    state       <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) grant_cmd <= (pick == SUB) ? sub_cmd : main_cmd;
        if (state == ST_ACCESS && !hit && mem_ok) mem_q <= mem_data;
        if (grant_done && grant_who == MAIN) main_rdata <= is_reg ? reg_rdata : mem_q;
        if (grant_done && grant_who == SUB)  sub_rdata  <= is_reg ? reg_rdata : mem_q;
    end

endmodule

`default_nettype wire

/* hw/shb_mapper.sv */
// ####################
// banking mapper
// per cpu bank registers, page translation,
// region decode, register window,
// sub reset register
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "shb_cfg.svh"

module shb_mapper(
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire                     grant_valid,
    input  shb_bus_pkg::master_e    grant_who,
    input  shb_bus_pkg::cpu_req_t   grant_cmd,
    input  wire                     grant_done,   // one cycle, from arbiter

    output logic                    is_reg,
    output logic [7:0]              reg_rdata,
    output shb_bus_pkg::phys_req_t  phys,

    output logic                    rom_cs,
    output logic                    ram_cs,
    output logic                    key_cs,

    output logic                    srst_n,       // sub cpu reset
    input  wire  [1:0]              irq_pend,     // [0] main, [1] sub
    output logic                    main_irq_clr,
    output logic                    sub_irq_clr
);
    import shb_bus_pkg::*;
    import shb_map_pkg::*;

    localparam logic [15:0] REG_BASE  = `SHB_REG_BASE;
    localparam logic [ 8:0] BOOT_BANK = `SHB_BOOT_BANK;

    logic [8:0]  bank_q [2][8];  // [master][page]
    phys_addr_u  pa;
    region_e     rgn;
    reg_off_e    off_sel;
    logic        in_win;
    logic        mem_sel;
    logic        reg_wr;
    logic        reg_rd;
    logic        ack_rd;

    // window is the top byte of the cpu address
    assign in_win  = grant_cmd.addr[15:8] == REG_BASE[15:8];
    assign is_reg  = grant_valid & in_win;
    assign mem_sel = grant_valid & ~in_win;

    // offset from addr[3:0], addr bit 4 is bank msb on writes
    assign off_sel = reg_off_e'({4'h0, grant_cmd.addr[3:0]});

    // page view: bank of the caller + 13 bit offset
    always_comb begin
        pa.page.bank = bank_q[grant_who][grant_cmd.addr[15:13]];
        pa.page.off  = grant_cmd.addr[12:0];
    end

    assign phys.addr  = pa;
    assign phys.wdata = grant_cmd.wdata;
    assign phys.rnw   = grant_cmd.rnw;

    // region view for chip selects
    assign rgn = region_e'(pa.region.rgn);

    always_comb begin
        rom_cs = 1'b0;
        ram_cs = 1'b0;
        key_cs = 1'b0;
        case (rgn)
            RGN_ROM, RGN_ROM1: rom_cs = mem_sel;
            RGN_RAM:           ram_cs = mem_sel;
            RGN_KEY:           key_cs = mem_sel;
            default:           rom_cs = 1'b0;
        endcase
    end

    // register window strobes, all at completion
    assign reg_wr = grant_done & is_reg & ~grant_cmd.rnw;
    assign reg_rd = grant_done & is_reg &  grant_cmd.rnw;
    assign ack_rd = reg_rd & (off_sel == IRQ_ACK);

    // only irq_ack reads back something
    assign reg_rdata = (off_sel == IRQ_ACK) ? {7'd0, irq_pend[grant_who]} : 8'd0;

    // caller clears its own flag
    assign main_irq_clr = ack_rd & (grant_who == MAIN);
    assign sub_irq_clr  = ack_rd & (grant_who == SUB);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int m = 0; m < 2; m++) begin
                for (int p = 0; p < 7; p++) begin
                    bank_q[m][p] <= 9'd0;
                end
                bank_q[m][7] <= BOOT_BANK;   // boot vector page
            end
            srst_n <= 1'b0;   // sub held until main lets go
        end else if (reg_wr) begin
            if (off_sel <= BANK7) begin
                // own bank set only
                bank_q[grant_who][grant_cmd.addr[2:0]] <=
                    {grant_cmd.addr[`SHB_BANK_HI_BIT], grant_cmd.wdata};
            end
            if (off_sel == SUB_RST && grant_who == MAIN) begin
                srst_n <= grant_cmd.wdata[0];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/shb_irq_ctrl.sv */
// ####################
// interrupt controller
// vblank fall -> irq pending for both cpus,
// firq fan-out
// ####################
`timescale 1ns/1ps
`default_nettype none

module shb_irq_ctrl(
    input  wire        clk,
    input  wire        rst_n,

    input  wire        lvbl,          // low during vblank
    input  wire        firqn,         // shared firq source
    input  wire        main_irq_clr,
    input  wire        sub_irq_clr,

    output logic [1:0] irq_pend,      // [0] main, [1] sub
    output logic       main_irq_n,
    output logic       sub_irq_n,
    output logic       main_firq_n,
    output logic       sub_firq_n
);

    logic lvbl_q;    // input register
    logic lvbl_l;    // delayed copy for edge detect
    logic vb_fall;
    logic firqn_q;

    assign vb_fall = lvbl_l & ~lvbl_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lvbl_q   <= 1'b0;   // no false edge out of reset
            lvbl_l   <= 1'b0;
            irq_pend <= 2'b00;
            firqn_q  <= 1'b1;
        end else begin
            lvbl_q  <= lvbl;
            lvbl_l  <= lvbl_q;
            firqn_q <= firqn;
            // new vblank beats a clear in the same cycle
            if (vb_fall)           irq_pend[0] <= 1'b1;
            else if (main_irq_clr) irq_pend[0] <= 1'b0;
            if (vb_fall)           irq_pend[1] <= 1'b1;
            else if (sub_irq_clr)  irq_pend[1] <= 1'b0;
        end
    end

    // active low, straight from the flags
    assign main_irq_n = ~irq_pend[0];
    assign sub_irq_n  = ~irq_pend[1];

    // one register, both cpus see the same firq
    assign main_firq_n = firqn_q;
    assign sub_firq_n  = firqn_q;

endmodule

`default_nettype wire

/* hw/shb_main.sv */
// ####################
// shared bus controller top
// arbiter + mapper + irq controller
// ####################
`timescale 1ns/1ps
`default_nettype none

module shb_main(
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    lvbl,
    input  wire                    firqn,

    // main cpu port
    input  wire                    main_req,
    input  shb_bus_pkg::cpu_req_t  main_cmd,
    output logic                   main_ack,
    output logic [7:0]             main_rdata,

    // sub cpu port
    input  wire                    sub_req,
    input  shb_bus_pkg::cpu_req_t  sub_cmd,
    output logic                   sub_ack,
    output logic [7:0]             sub_rdata,

    // shared physical bus
    output logic [21:0]            baddr,
    output logic [7:0]             bdout,
    output logic                   brnw,

    output logic                   rom_cs,
    output logic                   ram_cs,
    output logic                   key_cs,
    input  wire                    rom_ok,
    input  wire                    ram_ok,
    input  wire  [7:0]             rom_data,
    input  wire  [7:0]             ram_dout,
    input  wire  [7:0]             key_dout,

    output logic                   srst_n,
    output logic                   bus_busy,

    output logic                   main_irq_n,
    output logic                   sub_irq_n,
    output logic                   main_firq_n,
    output logic                   sub_firq_n
);
    import shb_bus_pkg::*;

    logic       grant_valid;
    master_e    grant_who;
    cpu_req_t   grant_cmd;
    logic       grant_done;
    logic       is_reg;
    logic [7:0] reg_rdata;
    phys_req_t  phys;
    logic [1:0] irq_pend;
    logic       main_irq_clr;
    logic       sub_irq_clr;

    // bus outputs come straight from the mapped request
    assign baddr = phys.addr;
    assign bdout = phys.wdata;
    assign brnw  = phys.rnw;

    shb_arbiter u_arb(
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .main_req    ( main_req    ),
        .main_cmd    ( main_cmd    ),
        .main_ack    ( main_ack    ),
        .main_rdata  ( main_rdata  ),
        .sub_req     ( sub_req     ),
        .sub_cmd     ( sub_cmd     ),
        .sub_ack     ( sub_ack     ),
        .sub_rdata   ( sub_rdata   ),
        .grant_valid ( grant_valid ),
        .grant_who   ( grant_who   ),
        .grant_cmd   ( grant_cmd   ),
        .grant_done  ( grant_done  ),
        .is_reg      ( is_reg      ),
        .reg_rdata   ( reg_rdata   ),
        .rom_cs      ( rom_cs      ),
        .ram_cs      ( ram_cs      ),
        .key_cs      ( key_cs      ),
        .rom_ok      ( rom_ok      ),
        .ram_ok      ( ram_ok      ),
        .rom_data    ( rom_data    ),
        .ram_dout    ( ram_dout    ),
        .key_dout    ( key_dout    ),
        .bus_busy    ( bus_busy    )   // cs with ok low
    );

    shb_mapper u_map(
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .grant_valid  ( grant_valid  ),
        .grant_who    ( grant_who    ),
        .grant_cmd    ( grant_cmd    ),
        .grant_done   ( grant_done   ),
        .is_reg       ( is_reg       ),
        .reg_rdata    ( reg_rdata    ),
        .phys         ( phys         ),
        .rom_cs       ( rom_cs       ),
        .ram_cs       ( ram_cs       ),
        .key_cs       ( key_cs       ),
        .srst_n       ( srst_n       ),
        .irq_pend     ( irq_pend     ),
        .main_irq_clr ( main_irq_clr ),
        .sub_irq_clr  ( sub_irq_clr  )
    );

    shb_irq_ctrl u_irq(
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .lvbl         ( lvbl         ),
        .firqn        ( firqn        ),
        .main_irq_clr ( main_irq_clr ),
        .sub_irq_clr  ( sub_irq_clr  ),
        .irq_pend     ( irq_pend     ),
        .main_irq_n   ( main_irq_n   ),
        .sub_irq_n    ( sub_irq_n    ),
        .main_firq_n  ( main_firq_n  ),
        .sub_firq_n   ( sub_firq_n   )
    );

endmodule

`default_nettype wire

/* dv/shb_tb.sv */
// ####################
// shared bus controller testbench
// rom/ram/key models, cpu port tasks,
// bus monitor, directed tests, watchdog
// ####################
`timescale 1ns/1ps
`default_nettype none

`include "shb_cfg.svh"

module shb_tb;
    import shb_bus_pkg::*;
    import shb_map_pkg::*;

    localparam int DRIVE_DLY   = 1;        // input skew after posedge
    localparam int N_TESTS     = 6;
    localparam int TEST_NS     = 3000;     // budget per test
    localparam int WATCHDOG_NS = N_TESTS * TEST_NS + 2000;
    localparam int HS_LIMIT    = 40;       // cycles per handshake phase
    localparam int RAM_WORDS   = 1024;
    localparam int ARB_ROUNDS  = 4;

    // bus state seen while ack is high
    typedef struct packed {
        logic [21:0] addr;
        logic [7:0]  wdata;
        logic        rnw;
        logic        rom;
        logic        ram;
        logic        key;
    } bus_snap_t;

    logic        clk;
    logic        rst_n;
    logic        lvbl;
    logic        firqn;
    logic        main_req;
    cpu_req_t    main_cmd;
    logic        main_ack;
    logic [7:0]  main_rdata;
    logic        sub_req;
    cpu_req_t    sub_cmd;
    logic        sub_ack;
    logic [7:0]  sub_rdata;
    logic [21:0] baddr;
    logic [7:0]  bdout;
    logic        brnw;
    logic        rom_cs;
    logic        ram_cs;
    logic        key_cs;
    logic        rom_ok;
    logic        ram_ok;
    logic [7:0]  rom_data;
    logic [7:0]  ram_dout;
    logic [7:0]  key_dout;
    logic        srst_n;
    logic        bus_busy;
    logic        main_irq_n;
    logic        sub_irq_n;
    logic        main_firq_n;
    logic        sub_firq_n;

    int          errors = 0;
    int          busy_cycles = 0;
    logic [31:0] lcg_state = 32'h916c_ab5c;
    logic [7:0]  ram [RAM_WORDS];
    int          rom_wait;
    logic        rom_busy = 1'b0;
    logic        ram_seen = 1'b0;
    master_e     served[$];               // ack order
    logic [21:0] prev_addr;
    logic        prev_cs = 1'b0;
    logic        prev_rnw;
    logic        main_ack_q = 1'b0;
    logic        sub_ack_q = 1'b0;

    shb_main UUT(.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("summary: %0d errors", errors);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rom content is a pure function of the physical address
    function automatic logic [7:0] rom_byte(input logic [21:0] pa);
        return pa[7:0] ^ 8'h5A;
    endfunction

    // bank joined with the 8 KB page offset
    function automatic logic [21:0] page_addr(input logic [8:0] bank, input logic [15:0] a);
        return {bank, a[12:0]};
    endfunction

    // bank bit 8 rides on a cpu address bit while bits 7:0 go as data
    function automatic logic [15:0] bank_addr(input logic [2:0] page, input logic [8:0] bank);
        return `SHB_REG_BASE | (16'(bank[8]) << `SHB_BANK_HI_BIT) | 16'(page);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // ram fill depends on every index bit
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
        end
    end

    // memory models driven just after the edge
    always @(posedge clk) begin
        #(DRIVE_DLY);
        if (rom_cs) begin
            if (!rom_busy) begin
                lcg_state = lcg_step(lcg_state);
                rom_wait  = lcg_state[17:16];   // 0..3 wait cycles
                rom_busy  = 1'b1;
            end else if (rom_wait != 0) begin
                rom_wait--;
            end
            rom_ok   = (rom_wait == 0);
            rom_data = rom_byte(baddr);
        end else begin
            rom_busy = 1'b0;
            rom_ok   = 1'b0;
        end
        if (ram_cs) begin
            ram_ok   = ram_seen;                // one cycle after select
            ram_seen = 1'b1;
            if (ram_ok && !brnw) ram[baddr[9:0]] = bdout;
            ram_dout = ram[baddr[9:0]];
        end else begin
            ram_seen = 1'b0;
            ram_ok   = 1'b0;
        end
    end

    // bus rules and ack order sampled mid cycle
    always @(negedge clk) begin
        logic any_cs;
        any_cs = rom_cs | ram_cs | key_cs;
        if (rst_n && any_cs) begin
            check("chip select one-hot", $countones({rom_cs, ram_cs, key_cs}) == 1, 1'b1);
            check("bus_busy", bus_busy, (rom_cs & ~rom_ok) | (ram_cs & ~ram_ok));
            if (bus_busy) busy_cycles++;
            if (prev_cs) begin
                check("baddr held", baddr, prev_addr);
                check("brnw held", brnw, prev_rnw);
            end
        end
        if (main_ack && !main_ack_q) served.push_back(MAIN);
        if (sub_ack && !sub_ack_q) served.push_back(SUB);
        prev_cs    = rst_n & any_cs;
        prev_addr  = baddr;
        prev_rnw   = brnw;
        main_ack_q = main_ack;
        sub_ack_q  = sub_ack;
    end

    // four phase handshake on one cpu port
    task automatic cpu_access(input master_e who, input logic [15:0] addr,
                              input logic [7:0] wdata, input logic rnw,
                              output logic [7:0] rdata, output bus_snap_t snap);
        cpu_req_t cmd;
        int       n;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd.rnw   = rnw;
        @(posedge clk);
        #(DRIVE_DLY);
        if (who == MAIN) begin
            main_cmd = cmd;
            main_req = 1'b1;
        end else begin
            sub_cmd = cmd;
            sub_req = 1'b1;
        end
        n = 0;
        while (((who == MAIN) ? main_ack : sub_ack) !== 1'b1 && n < HS_LIMIT) begin
            @(posedge clk);
            #(DRIVE_DLY);
            n++;
        end
        if (n >= HS_LIMIT) begin
            errors++;
            $display("%s port got no ack for address 0x%h", who.name(), addr);
        end
        rdata      = (who == MAIN) ? main_rdata : sub_rdata;
        snap.addr  = baddr;
        snap.wdata = bdout;
        snap.rnw   = brnw;
        snap.rom   = rom_cs;
        snap.ram   = ram_cs;
        snap.key   = key_cs;
        if (who == MAIN) main_req = 1'b0;
        else             sub_req  = 1'b0;
        n = 0;
        while (((who == MAIN) ? main_ack : sub_ack) !== 1'b0 && n < HS_LIMIT) begin
            @(posedge clk);
            #(DRIVE_DLY);
            n++;
        end
        if (n >= HS_LIMIT) begin
            errors++;
            $display("%s port ack stayed high after req dropped", who.name());
        end
    endtask

    task automatic main_access(input logic [15:0] addr, input logic [7:0] wdata,
                               input logic rnw, output logic [7:0] rdata,
                               output bus_snap_t snap);
        cpu_access(MAIN, addr, wdata, rnw, rdata, snap);
    endtask

    task automatic sub_access(input logic [15:0] addr, input logic [7:0] wdata,
                              input logic rnw, output logic [7:0] rdata,
                              output bus_snap_t snap);
        cpu_access(SUB, addr, wdata, rnw, rdata, snap);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
    endtask

    task automatic test_reset_boot();
        logic [7:0] rd;
        bus_snap_t  s;
        $display("test 1: reset state and boot read");
        check("srst_n", srst_n, 1'b0);
        check("acks", {main_ack, sub_ack}, 2'b00);
        check("chip selects", {rom_cs, ram_cs, key_cs}, 3'b000);
        check("irq_n", {main_irq_n, sub_irq_n}, 2'b11);
        check("firq_n", {main_firq_n, sub_firq_n}, 2'b11);
        main_access(16'hE010, 8'h00, 1'b1, rd, s);   // page 7
        check("boot baddr", s.addr, page_addr(`SHB_BOOT_BANK, 16'hE010));
        check("boot rom_cs", s.rom, 1'b1);
        check("boot data", rd, rom_byte(page_addr(`SHB_BOOT_BANK, 16'hE010)));
    endtask

    task automatic test_banking();
        logic [7:0] rd;
        bus_snap_t  s;
        $display("test 2: main bank 2 to ram");
        main_access(bank_addr(3'd2, 9'h100), 8'h00, 1'b0, rd, s);
        main_access(16'h4123, 8'h9C, 1'b0, rd, s);
        check("ram write cs", s.ram, 1'b1);
        check("ram write baddr", s.addr, page_addr(9'h100, 16'h4123));
        check("ram write bdout", s.wdata, 8'h9C);
        check("ram write brnw", s.rnw, 1'b0);
        main_access(16'h4123, 8'h00, 1'b1, rd, s);
        check("ram read brnw", s.rnw, 1'b1);
        check("ram read data", rd, 8'h9C);
        // sub bank 2 keeps its reset value so this is rom
        sub_access(16'h4123, 8'h00, 1'b1, rd, s);
        check("sub bank2 baddr", s.addr, page_addr(9'h000, 16'h4123));
        check("sub bank2 rom_cs", s.rom, 1'b1);
        check("sub bank2 data", rd, rom_byte(page_addr(9'h000, 16'h4123)));
    endtask

    task automatic test_sub_enable();
        logic [7:0] rd;
        bus_snap_t  s;
        $display("test 3: sub release and separate banks");
        check("srst_n before release", srst_n, 1'b0);
        main_access(`SHB_REG_BASE | 16'(SUB_RST), 8'h01, 1'b0, rd, s);
        check("srst_n after main write", srst_n, 1'b1);
        sub_access(`SHB_REG_BASE | 16'(SUB_RST), 8'h00, 1'b0, rd, s);   // not allowed
        check("srst_n after sub write", srst_n, 1'b1);
        sub_access(bank_addr(3'd0, 9'h180), 8'h80, 1'b0, rd, s);       // key region
        sub_access(16'h0042, 8'h00, 1'b1, rd, s);
        check("sub key cs", s.key, 1'b1);
        check("sub key baddr", s.addr, page_addr(9'h180, 16'h0042));
        check("sub key data", rd, 8'hC3);
        main_access(16'h0042, 8'h00, 1'b1, rd, s);
        check("main bank0 baddr", s.addr, page_addr(9'h000, 16'h0042));
        check("main bank0 data", rd, rom_byte(page_addr(9'h000, 16'h0042)));
    endtask

    task automatic test_arbitration();
        logic [7:0]  rd_m;
        logic [7:0]  rd_s;
        logic [7:0]  rd_w;
        logic [15:0] a_m;
        logic [15:0] a_s;
        logic [15:0] a_w;
        bus_snap_t   s_m;
        bus_snap_t   s_s;
        bus_snap_t   s_w;
        master_e     last_exp;    // last served master per fairness rule
        master_e     win;
        master_e     expect_q[$];
        $display("test 4: two masters tied on every round");
        apply_reset();
        served.delete();
        last_exp = SUB;           // main takes the first tie after reset
        for (int i = 0; i < ARB_ROUNDS; i++) begin
            a_m = 16'hE000 + 16'(i * 17);
            a_s = 16'hE800 + 16'(i * 19);
            fork
                main_access(a_m, 8'h00, 1'b1, rd_m, s_m);
                sub_access(a_s, 8'h00, 1'b1, rd_s, s_s);
            join
            check("main arb data", rd_m, rom_byte(page_addr(`SHB_BOOT_BANK, a_m)));
            check("sub arb data", rd_s, rom_byte(page_addr(`SHB_BOOT_BANK, a_s)));
            // tie goes to the master not served last and the loser follows
            win = (last_exp == MAIN) ? SUB : MAIN;
            expect_q.push_back(win);
            expect_q.push_back((win == MAIN) ? SUB : MAIN);
            // winner goes once more alone so the next tie flips
            a_w = (win == MAIN) ? a_m : a_s;
            cpu_access(win, a_w, 8'h00, 1'b1, rd_w, s_w);
            check("solo arb data", rd_w, rom_byte(page_addr(`SHB_BOOT_BANK, a_w)));
            expect_q.push_back(win);
            last_exp = win;
        end
        check("grants served", served.size(), expect_q.size());
        for (int k = 0; k < expect_q.size() && k < served.size(); k++) begin
            check("grant order", served[k], expect_q[k]);
        end
    endtask

    task automatic test_wait_states();
        logic [7:0]  rd;
        logic [15:0] a;
        bus_snap_t   s;
        $display("test 5: rom wait states");
        busy_cycles = 0;
        for (int i = 0; i < 10; i++) begin
            a = 16'hE000 + 16'(i * 16'h0151);
            main_access(a, 8'h00, 1'b1, rd, s);
            check("wait read baddr", s.addr, page_addr(`SHB_BOOT_BANK, a));
            check("wait read data", rd, rom_byte(page_addr(`SHB_BOOT_BANK, a)));
        end
        if (busy_cycles == 0) begin
            errors++;
            $display("no rom wait state was seen, bus_busy never went high");
        end
    endtask

    task automatic test_interrupts();
        logic [7:0] rd;
        bus_snap_t  s;
        $display("test 6: vblank irq and firq");
        @(posedge clk);
        #(DRIVE_DLY);
        lvbl = 1'b0;
        @(posedge clk);
        #(DRIVE_DLY);
        check("irq_n one cycle after vblank", {main_irq_n, sub_irq_n}, 2'b11);
        @(posedge clk);
        #(DRIVE_DLY);
        check("irq_n two cycles after vblank", {main_irq_n, sub_irq_n}, 2'b00);
        lvbl = 1'b1;
        main_access(`SHB_REG_BASE | 16'(IRQ_ACK), 8'h00, 1'b1, rd, s);
        check("main irq_ack data", rd, 8'h01);
        check("irq_n after main clear", {main_irq_n, sub_irq_n}, 2'b10);
        sub_access(`SHB_REG_BASE | 16'(IRQ_ACK), 8'h00, 1'b1, rd, s);
        check("sub irq_ack data", rd, 8'h01);
        check("irq_n after sub clear", {main_irq_n, sub_irq_n}, 2'b11);
        @(posedge clk);
        #(DRIVE_DLY);
        firqn = 1'b0;
        @(posedge clk);
        #(DRIVE_DLY);
        check("firq_n one cycle after firqn", {main_firq_n, sub_firq_n}, 2'b00);
        firqn = 1'b1;
        @(posedge clk);
        #(DRIVE_DLY);
        check("firq_n after release", {main_firq_n, sub_firq_n}, 2'b11);
    endtask

    initial begin
        rst_n    = 1'b0;
        lvbl     = 1'b1;
        firqn    = 1'b1;
        main_req = 1'b0;
        main_cmd = '0;
        sub_req  = 1'b0;
        sub_cmd  = '0;
        rom_ok   = 1'b0;
        ram_ok   = 1'b0;
        rom_data = 8'h00;
        ram_dout = 8'h00;
        key_dout = 8'hC3;   // key chip answers one fixed byte
        repeat (2) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        test_reset_boot();
        test_banking();
        test_sub_enable();
        test_arbitration();
        test_wait_states();
        test_interrupts();
        $display("summary: %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/shb_bus_pkg.sv
hw/shb_map_pkg.sv
hw/shb_arbiter.sv
hw/shb_mapper.sv
hw/shb_irq_ctrl.sv
hw/shb_main.sv
dv/shb_tb.sv
